// ==== ctrl_tx_settings.svh ====
/*
 * Control-frame transmit path settings.
 * Bus region, frame buffer and port FIFO sizes, and the bit
 * positions of the fields in the configuration word.
 */
`ifndef CTRL_TX_SETTINGS_SVH
`define CTRL_TX_SETTINGS_SVH

`define FRAME_RAM_REGION 8'h05  // top address byte served by the frame buffer
`define FRAME_RAM_WORDS  16     // 32-bit words, 64 bytes
`define PHY_PORTS        4
`define PHY_FIFO_DEPTH   16     // power of two, pointers wrap

// configuration word layout
`define CFG_TX_BIT       31
`define CFG_READY_BIT    30
`define CFG_BUSY_BIT     29
`define CFG_ABORT_BIT    28
`define CFG_PORT_LSB     24     // one-hot port field, PHY_PORTS wide
`define CFG_LEN_LSB      14     // 10-bit field, byte count minus one

`endif

// ==== ctrl_tx_pkg.sv ====
/*
 * Control-frame transmit path types.
 * Port masks, the byte unit carried through every stream and FIFO,
 * the CPU bus request and the configuration write.
 */
`include "ctrl_tx_settings.svh"

package ctrl_tx_pkg;

	typedef logic [`PHY_PORTS-1:0] port_mask_t;  // one bit per port

	typedef struct packed {
		logic [7:0] data;
		logic       last;  // final byte of a frame
	} tx_byte_t;

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
	} mem_req_t;

	typedef struct packed {
		logic [3:0]  we;  // byte lane enables
		logic [31:0] di;
	} cfg_wr_t;

endpackage

// ==== frame_issuer.sv ====
/*
 * Frame issuer.
 * CPU-visible 64-byte frame buffer and configuration register, plus the
 * FSM that requests the selected ports, pushes the frame one byte per
 * cycle in little-endian order and releases the ports afterwards.
 */
`timescale 1ns/1ps
`include "ctrl_tx_settings.svh"

module frame_issuer (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    mem_valid,
	input  ctrl_tx_pkg::mem_req_t   mem_req,
	output logic                    mem_ready,
	output logic [31:0]             mem_rdata,
	input  ctrl_tx_pkg::cfg_wr_t    cfg_wr,
	output logic [31:0]             cfg_rdata,
	output ctrl_tx_pkg::port_mask_t iss_req,
	input  logic                    iss_grant,
	output logic                    iss_valid,
	output ctrl_tx_pkg::tx_byte_t   iss_byte,
	input  logic                    iss_ready
);
	import ctrl_tx_pkg::*;

	localparam int WORD_AW = $clog2(`FRAME_RAM_WORDS);
	localparam int BYTE_AW = WORD_AW + 2;

	typedef enum logic [1:0] {S_IDLE, S_WAIT, S_SEND, S_END} state_t;

	logic [31:0]        frame_ram [`FRAME_RAM_WORDS];
	logic [WORD_AW-1:0] mem_idx;
	logic               mem_hit;

	logic               cfg_tx;
	logic               cfg_busy;
	logic               cfg_abort;
	port_mask_t         cfg_port;
	logic [9:0]         cfg_len;
	logic               tx_set;

	state_t             state;
	logic [BYTE_AW-1:0] tx_len;    // latched byte count minus one
	logic [BYTE_AW-1:0] byte_idx;  // index of the byte in iss_byte
	logic [BYTE_AW-1:0] load_idx;
	tx_byte_t           load_byte;
	logic               byte_load;

	// byte address, word index from bits above the lane
	assign mem_idx = mem_req.addr[WORD_AW+1:2];
	assign mem_hit = mem_valid && !mem_ready &&
		(mem_req.addr[31:24] == `FRAME_RAM_REGION);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			mem_ready <= 1'b0;
		else
			mem_ready <= mem_hit;  // single-cycle pulse
	end

	// read returns the word as it was before the lane merge
	always_ff @(posedge clk)
	begin
		if (mem_hit)
		begin
			mem_rdata <= frame_ram[mem_idx];
			for (int b = 0; b < 4; b++)
				if (mem_req.wstrb[b])
					frame_ram[mem_idx][b*8 +: 8] <= mem_req.wdata[b*8 +: 8];
		end
	end

	always_comb
	begin
		cfg_rdata                              = '0;
		cfg_rdata[`CFG_TX_BIT]                 = cfg_tx;
		cfg_rdata[`CFG_READY_BIT]              = !cfg_busy;
		cfg_rdata[`CFG_BUSY_BIT]               = cfg_busy;
		cfg_rdata[`CFG_ABORT_BIT]              = cfg_abort;
		cfg_rdata[`CFG_PORT_LSB +: `PHY_PORTS] = cfg_port;
		cfg_rdata[`CFG_LEN_LSB +: 10]          = cfg_len;
	end

	// a second tx write before the first is taken is not a new start
	assign tx_set = cfg_wr.we[3] && cfg_wr.di[`CFG_TX_BIT] && !cfg_busy && !cfg_tx;

	// first byte on grant, then the next one each time a byte moves
	assign load_idx       = (state == S_WAIT) ? '0 : byte_idx + 1'b1;
	assign load_byte.data = frame_ram[load_idx[BYTE_AW-1:2]][load_idx[1:0]*8 +: 8];
	assign load_byte.last = (load_idx == tx_len);
	assign byte_load      = !cfg_abort &&
		((state == S_WAIT && iss_grant) ||
		 (state == S_SEND && iss_valid && iss_ready && !iss_byte.last));

	always_ff @(posedge clk)
	begin
		if (state == S_IDLE && cfg_tx)
			tx_len <= cfg_len[BYTE_AW-1:0];
		if (byte_load)
			iss_byte <= load_byte;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state     <= S_IDLE;
			cfg_tx    <= 1'b0;
			cfg_busy  <= 1'b0;
			cfg_abort <= 1'b0;
			cfg_port  <= '0;
			cfg_len   <= '0;
			iss_req   <= '0;
			iss_valid <= 1'b0;
			byte_idx  <= '0;
		end
		else
		begin
			if (cfg_abort)
				cfg_abort <= 1'b0;  // one-shot
			if (byte_load)
				byte_idx <= load_idx;

			if (cfg_abort && (state == S_WAIT || state == S_SEND))
			begin
				iss_req   <= '0;  // drop locks, keep what was already pushed
				iss_valid <= 1'b0;
				state     <= S_END;
			end
			else
			begin
				case (state)
					S_IDLE:
					begin
						if (cfg_tx)
						begin
							cfg_tx   <= 1'b0;
							cfg_busy <= 1'b1;
							iss_req  <= cfg_port;
							state    <= S_WAIT;
						end
					end
					S_WAIT:
					begin
						if (iss_grant)
						begin
							iss_valid <= 1'b1;
							state     <= S_SEND;
						end
					end
					S_SEND:
					begin
						if (iss_valid && iss_ready && iss_byte.last)
						begin
							iss_valid <= 1'b0;
							state     <= S_END;
						end
					end
					S_END:
					begin
						// release the ports first, busy drops one edge later
						if (iss_req != '0)
							iss_req <= '0;
						else
						begin
							cfg_busy <= 1'b0;
							state    <= S_IDLE;
						end
					end
					default: state <= S_IDLE;
				endcase
			end

			if (tx_set)
				cfg_tx <= 1'b1;
			if (cfg_wr.we[3])
			begin
				cfg_port <= cfg_wr.di[`CFG_PORT_LSB +: `PHY_PORTS];
				if (cfg_busy)
					cfg_abort <= cfg_wr.di[`CFG_ABORT_BIT];  // ignored when idle
			end
			if (cfg_wr.we[2])
				cfg_len[9:2] <= cfg_wr.di[`CFG_LEN_LSB+2 +: 8];
			if (cfg_wr.we[1])
				cfg_len[1:0] <= cfg_wr.di[`CFG_LEN_LSB +: 2];
		end
	end

endmodule

// ==== phy_port_arbiter.sv ====
/*
 * Port lock arbiter.
 * Each port FIFO is owned by the issuer, by the forwarding stream or
 * by nobody. A source only writes into ports it owns, so frames of the
 * two sources never interleave inside one FIFO.
 */
`timescale 1ns/1ps

module phy_port_arbiter (
	input  logic                    clk,
	input  logic                    arst_n,
	input  ctrl_tx_pkg::port_mask_t iss_req,
	output logic                    iss_grant,
	input  logic                    iss_valid,
	input  ctrl_tx_pkg::tx_byte_t   iss_byte,
	output logic                    iss_ready,
	input  logic                    fwd_valid,
	input  ctrl_tx_pkg::tx_byte_t   fwd_byte,
	input  ctrl_tx_pkg::port_mask_t fwd_port,
	output logic                    fwd_ready,
	output ctrl_tx_pkg::port_mask_t fifo_push,
	input  ctrl_tx_pkg::port_mask_t fifo_full,
	output ctrl_tx_pkg::tx_byte_t   fifo_din
);
	import ctrl_tx_pkg::*;

	port_mask_t own_iss;
	port_mask_t own_fwd;
	port_mask_t free_ports;
	port_mask_t fwd_claim;
	logic       iss_xfer;

	assign free_ports = ~(own_iss | own_fwd);
	assign fwd_claim  = fwd_valid ? fwd_port : '0;

	// stream may write into a free port or one it already holds
	assign fwd_ready = fwd_valid && (fwd_port != '0) &&
		((fwd_port & own_iss) == '0) && ((fwd_port & fifo_full) == '0);

	assign iss_grant = (iss_req != '0) && ((iss_req & ~own_iss) == '0);
	// one shared data bus, the stream takes it when both could move
	assign iss_ready = iss_grant && ((iss_req & fifo_full) == '0) && !fwd_ready;
	assign iss_xfer  = iss_valid && iss_ready;

	assign fifo_din  = fwd_ready ? fwd_byte : iss_byte;
	assign fifo_push = fwd_ready ? fwd_port : (iss_xfer ? iss_req : '0);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			own_iss <= '0;
			own_fwd <= '0;
		end
		else
		begin
			// issuer holds while requesting, and loses a tie on a free port
			own_iss <= iss_req & (own_iss | (free_ports & ~fwd_claim));
			if (fwd_ready)
				own_fwd <= fwd_byte.last ? (own_fwd & ~fwd_port) : (own_fwd | fwd_port);
		end
	end

endmodule

// ==== phy_tx_fifo.sv ====
/*
 * Port transmit FIFO.
 * Circular buffer with an occupancy count and a valid/ready output.
 * Writers must respect full, a push while full is not checked here.
 */
`timescale 1ns/1ps
`include "ctrl_tx_settings.svh"

module phy_tx_fifo #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     push,
	input  payload_t din,
	output logic     full,
	output logic     pop_valid,
	output payload_t dout,
	input  logic     pop_ready
);
	localparam int AW = $clog2(`PHY_FIFO_DEPTH);

	payload_t      mem [`PHY_FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	logic          pop;

	assign pop_valid = (count != '0);
	assign full      = (count == (AW+1)'(`PHY_FIFO_DEPTH));
	assign pop       = pop_valid && pop_ready;
	assign dout      = mem[rd_ptr];  // visible the cycle after the push

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== ctrl_tx_top.sv ====
/*
 * Control-frame transmit path, top level.
 * Frame issuer and forwarding stream share four port FIFOs through
 * the lock arbiter, each FIFO drains to its own PHY-side output.
 */
`timescale 1ns/1ps
`include "ctrl_tx_settings.svh"

module ctrl_tx_top (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    mem_valid,
	input  ctrl_tx_pkg::mem_req_t   mem_req,
	output logic                    mem_ready,
	output logic [31:0]             mem_rdata,
	input  ctrl_tx_pkg::cfg_wr_t    cfg_wr,
	output logic [31:0]             cfg_rdata,
	input  logic                    fwd_valid,
	input  ctrl_tx_pkg::tx_byte_t   fwd_byte,
	input  ctrl_tx_pkg::port_mask_t fwd_port,
	output logic                    fwd_ready,
	output logic [`PHY_PORTS-1:0]   phy_valid,
	output ctrl_tx_pkg::tx_byte_t   phy_byte [`PHY_PORTS],
	input  logic [`PHY_PORTS-1:0]   phy_ready
);
	import ctrl_tx_pkg::*;

	port_mask_t iss_req;
	logic       iss_grant;
	logic       iss_valid;
	logic       iss_ready;
	tx_byte_t   iss_byte;
	port_mask_t fifo_push;
	port_mask_t fifo_full;
	tx_byte_t   fifo_din;

	frame_issuer u_issuer (
		.clk       (clk),
		.arst_n    (arst_n),
		.mem_valid (mem_valid),
		.mem_req   (mem_req),
		.mem_ready (mem_ready),
		.mem_rdata (mem_rdata),
		.cfg_wr    (cfg_wr),
		.cfg_rdata (cfg_rdata),
		.iss_req   (iss_req),
		.iss_grant (iss_grant),
		.iss_valid (iss_valid),
		.iss_byte  (iss_byte),
		.iss_ready (iss_ready)
	);

	phy_port_arbiter u_arbiter (
		.clk       (clk),
		.arst_n    (arst_n),
		.iss_req   (iss_req),
		.iss_grant (iss_grant),
		.iss_valid (iss_valid),
		.iss_byte  (iss_byte),
		.iss_ready (iss_ready),
		.fwd_valid (fwd_valid),
		.fwd_byte  (fwd_byte),
		.fwd_port  (fwd_port),
		.fwd_ready (fwd_ready),
		.fifo_push (fifo_push),
		.fifo_full (fifo_full),
		.fifo_din  (fifo_din)
	);

	for (genvar p = 0; p < `PHY_PORTS; p++)
	begin : g_port
		phy_tx_fifo #(
			.payload_t (tx_byte_t)
		) u_fifo (
			.clk       (clk),
			.arst_n    (arst_n),
			.push      (fifo_push[p]),
			.din       (fifo_din),  // shared, push selects the ports
			.full      (fifo_full[p]),
			.pop_valid (phy_valid[p]),
			.dout      (phy_byte[p]),
			.pop_ready (phy_ready[p])
		);
	end

endmodule

// ==== ctrl_tx_assertions.sv ====
/*
 * Transmit path protocol checks.
 * Bound into the top level: bus ready pulse width, port output
 * hold under back-pressure and exclusive use of a port per frame.
 */
`timescale 1ns/1ps
`include "ctrl_tx_settings.svh"

module ctrl_tx_assertions (
	input logic                    clk,
	input logic                    arst_n,
	input logic                    mem_ready,
	input logic [`PHY_PORTS-1:0]   phy_valid,
	input ctrl_tx_pkg::tx_byte_t   phy_byte [`PHY_PORTS],
	input logic [`PHY_PORTS-1:0]   phy_ready,
	input logic                    fwd_valid,
	input logic                    fwd_ready,
	input ctrl_tx_pkg::port_mask_t fwd_port,
	input ctrl_tx_pkg::tx_byte_t   fwd_byte,
	input logic                    iss_valid,
	input logic                    iss_ready,
	input ctrl_tx_pkg::port_mask_t iss_req,
	input ctrl_tx_pkg::tx_byte_t   iss_byte
);
	import ctrl_tx_pkg::*;

	int         violations = 0;  // failed assertions so far
	port_mask_t fwd_open;        // ports inside an unfinished forwarding frame
	port_mask_t iss_open;        // ports inside an unfinished issuer frame
	logic       fwd_xfer;
	logic       iss_xfer;

	assign fwd_xfer = fwd_valid && fwd_ready;
	assign iss_xfer = iss_valid && iss_ready;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			fwd_open <= '0;
			iss_open <= '0;
		end
		else
		begin
			if (fwd_xfer && fwd_byte.last)
				fwd_open <= fwd_open & ~fwd_port;
			else if (fwd_xfer)
				fwd_open <= fwd_open | fwd_port;
			if (iss_req == '0)
				iss_open <= '0;  // released or aborted
			else if (iss_xfer)
				iss_open <= iss_byte.last ? '0 : iss_req;
		end
	end

	a_mem_ready_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		mem_ready |=> !mem_ready)
	else
	begin
		$error("mem_ready high for two cycles");
		violations++;
	end

	for (genvar p = 0; p < `PHY_PORTS; p++)
	begin : g_port
		a_phy_hold: assert property (@(posedge clk) disable iff (!arst_n)
			phy_valid[p] && !phy_ready[p] |=> phy_valid[p] && $stable(phy_byte[p]))
		else
		begin
			$error("port %0d output changed while stalled", p);
			violations++;
		end
	end

	// a byte of one source entering a port that the other source is using
	a_no_overlap: assert property (@(posedge clk) disable iff (!arst_n)
		!(fwd_xfer && ((fwd_port & (iss_open | (iss_xfer ? iss_req : '0))) != '0)) &&
		!(iss_xfer && ((iss_req & fwd_open) != '0)))
	else
	begin
		$error("issuer and forwarding stream wrote the same port within one frame");
		violations++;
	end

endmodule

bind ctrl_tx_top ctrl_tx_assertions u_assert (
	.clk       (clk),
	.arst_n    (arst_n),
	.mem_ready (mem_ready),
	.phy_valid (phy_valid),
	.phy_byte  (phy_byte),
	.phy_ready (phy_ready),
	.fwd_valid (fwd_valid),
	.fwd_ready (fwd_ready),
	.fwd_port  (fwd_port),
	.fwd_byte  (fwd_byte),
	.iss_valid (iss_valid),
	.iss_ready (iss_ready),
	.iss_req   (iss_req),
	.iss_byte  (iss_byte)
);

// ==== ctrl_tx_tb.sv ====
/*
 * Testbench for the control-frame transmit path.
 * Directed tests for the frame buffer, configuration register,
 * single-port and multicast frames, lock contention with abort and
 * frame separation between the issuer and the forwarding stream.
 */
`timescale 1ns/1ps
`include "ctrl_tx_settings.svh"

module ctrl_tx_tb;
	import ctrl_tx_pkg::*;

	localparam int          LIMIT      = 4000;  // cycles allowed per wait
	localparam logic [31:0] READY_WORD = 32'h1 << `CFG_READY_BIT;

	typedef tx_byte_t byte_q_t [$];

	logic                  clk;
	logic                  arst_n;
	logic                  mem_valid;
	mem_req_t              mem_req;
	logic                  mem_ready;
	logic [31:0]           mem_rdata;
	cfg_wr_t               cfg_wr;
	logic [31:0]           cfg_rdata;
	logic                  fwd_valid;
	tx_byte_t              fwd_byte;
	port_mask_t            fwd_port;
	logic                  fwd_ready;
	logic [`PHY_PORTS-1:0] phy_valid;
	tx_byte_t              phy_byte [`PHY_PORTS];
	logic [`PHY_PORTS-1:0] phy_ready;

	int                    seed = 37;
	int                    stall_seed = 37;  // own stream for the drain pattern
	int                    errors;
	int                    tests_passed;
	int                    tests_failed;
	logic [`PHY_PORTS-1:0] stall_en;
	logic [7:0]            ram_model [4*`FRAME_RAM_WORDS];
	tx_byte_t              rx_q [`PHY_PORTS][$];
	byte_q_t               fwd_frame;

	ctrl_tx_top dut0 (.*);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// PHY side: collect accepted bytes, stall selected ports at random
	always @(posedge clk)
	begin
		for (int p = 0; p < `PHY_PORTS; p++)
		begin
			if (phy_valid[p] && phy_ready[p])
				rx_q[p].push_back(phy_byte[p]);
			if (stall_en[p])
				phy_ready[p] <= (($random(stall_seed) % 3) != 0);
			else
				phy_ready[p] <= 1'b1;
		end
	end

	task automatic check_equal(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected,
				actual);
			errors++;
		end
	endtask

	task automatic stop_on_timeout(input string what);
		$display("timeout: %s did not happen within %0d cycles", what, LIMIT);
		$display("Simulation FAILED");
		$finish;
	endtask

	task automatic finish_test(input string name, input int errors_before);
		if (errors == errors_before)
		begin
			tests_passed++;
			$display("test %s: passed", name);
		end
		else
		begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errors - errors_before);
		end
	endtask

	task automatic bus_access(input logic [3:0] idx, input logic [31:0] wdata,
		input logic [3:0] wstrb, output logic [31:0] rdata);
		int t;
		@(posedge clk);
		mem_valid <= 1'b1;
		mem_req   <= '{addr: {`FRAME_RAM_REGION, 18'h0, idx, 2'b00}, wdata: wdata,
			wstrb: wstrb};
		t = 0;
		do
		begin
			@(negedge clk);
			t++;
		end
		while (!mem_ready && t < LIMIT);
		if (!mem_ready)
			stop_on_timeout("mem_ready");
		rdata = mem_rdata;
		@(posedge clk);
		mem_valid <= 1'b0;
	endtask

	// bus write that also keeps the expected buffer contents
	task automatic write_word(input logic [3:0] idx, input logic [31:0] data,
		input logic [3:0] strb, output logic [31:0] rdata);
		bus_access(idx, data, strb, rdata);
		for (int b = 0; b < 4; b++)
			if (strb[b])
				ram_model[idx*4+b] = data[b*8 +: 8];
	endtask

	function automatic logic [31:0] model_word(input logic [3:0] idx);
		return {ram_model[idx*4+3], ram_model[idx*4+2], ram_model[idx*4+1], ram_model[idx*4]};
	endfunction

	task automatic fill_buffer();
		logic [31:0] rd;
		for (int w = 0; w < `FRAME_RAM_WORDS; w++)
			write_word(4'(w), $random(seed), 4'hf, rd);
	endtask

	function automatic logic [31:0] cfg_word(input logic tx, input logic abort,
		input port_mask_t port, input int len);
		logic [31:0] w;
		w                                = '0;
		w[`CFG_TX_BIT]                   = tx;
		w[`CFG_ABORT_BIT]                = abort;
		w[`CFG_PORT_LSB +: `PHY_PORTS]   = port;
		w[`CFG_LEN_LSB +: 10]            = 10'(len);
		return w;
	endfunction

	task automatic cfg_write(input logic [3:0] we, input logic [31:0] di);
		@(posedge clk);
		cfg_wr <= '{we: we, di: di};
		@(posedge clk);
		cfg_wr <= '0;
	endtask

	task automatic wait_busy(input logic level);
		int t;
		t = 0;
		do
		begin
			@(negedge clk);
			t++;
		end
		while (cfg_rdata[`CFG_BUSY_BIT] !== level && t < LIMIT);
		if (cfg_rdata[`CFG_BUSY_BIT] !== level)
			stop_on_timeout(level ? "busy rising" : "busy falling");
	endtask

	task automatic wait_rx(input int p, input int n);
		int t;
		t = 0;
		do
		begin
			@(negedge clk);
			t++;
		end
		while (rx_q[p].size() < n && t < LIMIT);
		if (rx_q[p].size() < n)
			stop_on_timeout($sformatf("arrival of %0d bytes at port %0d", n, p));
	endtask

	task automatic clear_rx();
		@(negedge clk);
		for (int p = 0; p < `PHY_PORTS; p++)
			rx_q[p].delete();
	endtask

	task automatic start_frame(input port_mask_t port, input int n);
		cfg_write(4'b1110, cfg_word(1'b1, 1'b0, port, n - 1));
		wait_busy(1'b1);
	endtask

	function automatic byte_q_t issuer_frame(input int n);
		byte_q_t  q;
		tx_byte_t b;
		for (int i = 0; i < n; i++)
		begin
			b.data = ram_model[i];  // little-endian within each word
			b.last = (i == n - 1);
			q.push_back(b);
		end
		return q;
	endfunction

	task automatic make_fwd_frame(input int n);
		tx_byte_t b;
		fwd_frame.delete();
		for (int i = 0; i < n; i++)
		begin
			b.data = 8'($random(seed));
			b.last = (i == n - 1);
			fwd_frame.push_back(b);
		end
	endtask

	task automatic send_fwd(input port_mask_t port, input int first, input int count);
		int t;
		for (int i = first; i < first + count; i++)
		begin
			@(posedge clk);
			fwd_valid <= 1'b1;
			fwd_port  <= port;
			fwd_byte  <= fwd_frame[i];
			t = 0;
			do
			begin
				@(negedge clk);
				t++;
			end
			while (!fwd_ready && t < LIMIT);
			if (!fwd_ready)
				stop_on_timeout("fwd_ready");
		end
		@(posedge clk);
		fwd_valid <= 1'b0;
	endtask

	task automatic check_frame(input string name, input int p, input int first,
		input byte_q_t exp);
		for (int i = 0; i < exp.size(); i++)
		begin
			if (first + i >= rx_q[p].size())
			begin
				$display("%s is short, byte %0d never reached port %0d", name, i, p);
				errors++;
				return;
			end
			check_equal($sformatf("%s byte %0d data", name, i), 32'(exp[i].data),
				32'(rx_q[p][first+i].data));
			check_equal($sformatf("%s byte %0d last", name, i), 32'(exp[i].last),
				32'(rx_q[p][first+i].last));
		end
	endtask

	task automatic test_buffer();
		int          e;
		logic [3:0]  idx;
		logic [3:0]  strb;
		logic [31:0] old;
		logic [31:0] rd;
		e = errors;
		fill_buffer();
		for (int k = 0; k < 4; k++)
		begin
			idx  = 4'(k*5 + 1);
			strb = 4'(k*3 + 5);  // mixed lane patterns
			old  = model_word(idx);
			write_word(idx, $random(seed), strb, rd);
			check_equal("mem_rdata during write", old, rd);
			write_word(idx, 32'h0, 4'h0, rd);
			check_equal("mem_rdata after merge", model_word(idx), rd);
		end
		finish_test("buffer access", e);
	endtask

	task automatic test_config();
		int e;
		e = errors;
		@(negedge clk);
		check_equal("cfg_rdata after reset", READY_WORD, cfg_rdata);
		cfg_write(4'b1110, cfg_word(1'b0, 1'b0, 4'b0100, 37));
		@(negedge clk);
		check_equal("cfg_rdata fields", cfg_word(1'b0, 1'b0, 4'b0100, 37) | READY_WORD,
			cfg_rdata);
		start_frame(4'b0100, 4);
		wait_busy(1'b0);
		check_equal("cfg_rdata after frame", cfg_word(1'b0, 1'b0, 4'b0100, 3) | READY_WORD,
			cfg_rdata);
		wait_rx(2, 4);
		finish_test("configuration readback", e);
	endtask

	task automatic test_single_port();
		int e;
		int lens [3];
		e    = errors;
		lens = '{1, 9, 64};
		for (int k = 0; k < 3; k++)
		begin
			clear_rx();
			fill_buffer();
			start_frame(4'b0100, lens[k]);
			wait_busy(1'b0);
			wait_rx(2, lens[k]);
			repeat (8) @(negedge clk);
			for (int p = 0; p < `PHY_PORTS; p++)
				check_equal($sformatf("port %0d byte count", p), (p == 2) ? lens[k] : 0,
					rx_q[p].size());
			check_frame($sformatf("port 2 frame of %0d", lens[k]), 2, 0,
				issuer_frame(lens[k]));
		end
		finish_test("single-port frame", e);
	endtask

	task automatic test_multicast();
		int e;
		e = errors;
		clear_rx();
		fill_buffer();
		stall_en = 4'b1000;  // port 3 drains slowly and fills up
		start_frame(4'b1001, 48);
		wait_busy(1'b0);
		wait_rx(0, 48);
		wait_rx(3, 48);
		stall_en = '0;
		repeat (4) @(negedge clk);
		check_equal("port 0 byte count", 48, rx_q[0].size());
		check_equal("port 3 byte count", 48, rx_q[3].size());
		check_frame("port 0 multicast", 0, 0, issuer_frame(48));
		check_frame("port 3 multicast", 3, 0, issuer_frame(48));
		finish_test("multicast under back-pressure", e);
	endtask

	task automatic test_abort();
		int e;
		e = errors;
		clear_rx();
		fill_buffer();
		make_fwd_frame(6);
		send_fwd(4'b0010, 0, 3);  // port 1 stays locked mid-frame
		start_frame(4'b0010, 10);
		repeat (20) @(negedge clk);
		check_equal("port 1 bytes while locked", 3, rx_q[1].size());
		cfg_write(4'b1000, cfg_word(1'b0, 1'b1, 4'b0010, 0));
		wait_busy(1'b0);
		send_fwd(4'b0010, 3, 3);
		wait_rx(1, 6);
		start_frame(4'b0010, 10);
		wait_busy(1'b0);
		wait_rx(1, 16);
		repeat (4) @(negedge clk);
		check_equal("port 1 byte count", 16, rx_q[1].size());
		check_frame("forwarding frame", 1, 0, fwd_frame);
		check_frame("issuer frame after abort", 1, 6, issuer_frame(10));
		finish_test("contention and abort", e);
	endtask

	task automatic test_interleave();
		int e;
		int first_len;
		e = errors;
		clear_rx();
		fill_buffer();
		make_fwd_frame(8);
		fork
			send_fwd(4'b0001, 0, 8);
			start_frame(4'b0001, 12);
		join
		wait_busy(1'b0);
		wait_rx(0, 20);
		repeat (4) @(negedge clk);
		check_equal("port 0 byte count", 20, rx_q[0].size());
		first_len = 0;
		for (int k = 0; k < rx_q[0].size(); k++)
			if (rx_q[0][k].last && first_len == 0)
				first_len = k + 1;
		// either source may win the port, the frames must stay whole
		if (first_len == 8)
		begin
			check_frame("forwarding frame first", 0, 0, fwd_frame);
			check_frame("issuer frame second", 0, 8, issuer_frame(12));
		end
		else
		begin
			check_frame("issuer frame first", 0, 0, issuer_frame(12));
			check_frame("forwarding frame second", 0, 12, fwd_frame);
		end
		finish_test("no interleaving", e);
	endtask

	initial
	begin
		arst_n       = 1'b0;
		mem_valid    = 1'b0;
		mem_req      = '0;
		cfg_wr       = '0;
		fwd_valid    = 1'b0;
		fwd_byte     = '0;
		fwd_port     = '0;
		phy_ready    = '1;
		stall_en     = '0;
		errors       = 0;
		tests_passed = 0;
		tests_failed = 0;
		repeat (16) @(posedge clk);
		arst_n <= 1'b1;
		@(posedge clk);
		test_config();
		test_buffer();
		test_single_port();
		test_multicast();
		test_abort();
		test_interleave();
		$display("tests passed: %0d, failed: %0d, assertion failures: %0d", tests_passed,
			tests_failed, dut0.u_assert.violations);
		if (tests_failed == 0 && dut0.u_assert.violations == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== ctrl_tx_top.f ====
+incdir+.
ctrl_tx_pkg.sv
frame_issuer.sv
phy_port_arbiter.sv
phy_tx_fifo.sv
ctrl_tx_top.sv
ctrl_tx_assertions.sv
ctrl_tx_tb.sv

// ==== Makefile ====
# Verilator build and run for the control-frame transmit path

VERILATOR ?= verilator
TOP       ?= ctrl_tx_tb
FILELIST  ?= ctrl_tx_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUNFLAGS  ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUNFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation PASSED$$"

clean:
	rm -rf $(OBJ_DIR)
